//--- rtl/lane_bus_if.sv
`timescale 1ns/1ns

interface lane_bus_if #(
    parameter int NUM_LANES = 16,
    parameter int DEPTH     = 32
);

    localparam int LANE_W = $clog2(NUM_LANES);
    localparam int ADDR_W = $clog2(DEPTH);

    // table write, one entry of one lane per strobe
    logic              wr_en;
    logic [LANE_W-1:0] wr_lane;
    logic [ADDR_W-1:0] wr_addr;
    logic              wr_weight;
    logic              wr_mask;

    // step broadcast, same vector to every lane
    logic                 step_valid;
    logic [ADDR_W-1:0]    step_addr;
    logic [NUM_LANES-1:0] step_act;
    // final step of the run
    logic                 step_last;

    // loader side
    modport src (
        output wr_en, wr_lane, wr_addr, wr_weight, wr_mask,
        output step_valid, step_addr, step_act, step_last
    );

    // lane side
    modport dst (
        input wr_en, wr_lane, wr_addr, wr_weight, wr_mask,
        input step_valid, step_addr, step_act, step_last
    );

endinterface

//--- rtl/lane_loader.sv
`timescale 1ns/1ns

module lane_loader #(
    parameter int NUM_LANES = 16,
    parameter int DEPTH     = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_valid,
    input  sign_vote_pkg::op_t           cmd_op,
    input  logic [$clog2(NUM_LANES)-1:0] cmd_lane,
    input  logic [$clog2(DEPTH)-1:0]     cmd_addr,
    input  logic                         cmd_weight,
    input  logic                         cmd_mask,
    input  logic [$clog2(DEPTH+1)-1:0]   cmd_len,
    input  logic                         act_valid,
    input  logic [NUM_LANES-1:0]         act,
    output logic                         busy,
    output logic                         run_start,
    lane_bus_if.src                      bus
);

    import sign_vote_pkg::*;

    localparam int ADDR_W       = $clog2(DEPTH);
    // loader, lane, adder and accumulator stages after the last step
    localparam int DRAIN_CYCLES = 4;

    loader_state_t     state;
    logic [ADDR_W-1:0] step_cnt;
    logic [ADDR_W-1:0] last_addr;
    logic [1:0]        drain_cnt;
    logic              cmd_take;
    logic              run_take;
    logic              act_take;

    // commands only seen while idle
    assign cmd_take = cmd_valid && (state == ST_IDLE);
    // zero length run is dropped
    assign run_take = cmd_take && (cmd_op == OP_RUN) && (cmd_len != '0);
    assign act_take = act_valid && (state == ST_RUN);

    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= ST_IDLE;
            step_cnt        <= '0;
            drain_cnt       <= '0;
            run_start       <= 1'b0;
            bus.wr_en       <= 1'b0;
            bus.step_valid  <= 1'b0;
        end else begin
            run_start      <= run_take;
            bus.wr_en      <= cmd_take && (cmd_op == OP_LOAD);
            bus.step_valid <= act_take;
            case (state)
                ST_IDLE: begin
                    if (run_take) begin
                        state    <= ST_RUN;
                        step_cnt <= '0;
                    end
                end
                ST_RUN: begin
                    if (act_take) begin
                        step_cnt <= step_cnt + 1'b1;
                        // final vector goes out this edge
                        if (step_cnt == last_addr) begin
                            state     <= ST_DRAIN;
                            drain_cnt <= '0;
                        end
                    end
                end
                ST_DRAIN: begin
                    // idle again in the cycle done pulses
                    if (drain_cnt == 2'(DRAIN_CYCLES - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // write fields, qualified by wr_en
    always_ff @(posedge clk) begin
        if (cmd_take) begin
            bus.wr_lane   <= cmd_lane;
            bus.wr_addr   <= cmd_addr;
            bus.wr_weight <= cmd_weight;
            bus.wr_mask   <= cmd_mask;
        end
        // run length kept as index of final step
        if (run_take) begin
            last_addr <= ADDR_W'(cmd_len - 1'b1);
        end
        // step fields, qualified by step_valid
        if (act_take) begin
            bus.step_addr <= step_cnt;
            bus.step_act  <= act;
            bus.step_last <= (step_cnt == last_addr);
        end
    end

endmodule

//--- rtl/sign_vote_pkg.sv
package sign_vote_pkg;

    // command opcodes carried on cmd_op
    typedef enum logic {
        // one weight/mask entry of one lane
        OP_LOAD = 1'b0,
        // clear accumulator, start a run
        OP_RUN  = 1'b1
    } op_t;

    // loader run FSM
    typedef enum logic [1:0] {
        // accepting commands
        ST_IDLE  = 2'd0,
        // accepting activation vectors
        ST_RUN   = 2'd1,
        // last step still in the pipe
        ST_DRAIN = 2'd2
    } loader_state_t;

    // per lane vote, two's complement
    typedef logic signed [1:0] vote_t;

    // mask bit clear
    localparam vote_t VOTE_ZERO = 2'sb00;
    // activation matches weight
    localparam vote_t VOTE_POS  = 2'sb01;
    // activation differs from weight
    localparam vote_t VOTE_NEG  = 2'sb11;

endpackage

//--- rtl/sign_vote_top.sv
`timescale 1ns/1ns

module sign_vote_top #(
    parameter int NUM_LANES = 16,
    parameter int DEPTH     = 32,
    parameter int ACC_W     = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_valid,
    input  sign_vote_pkg::op_t           cmd_op,
    input  logic [$clog2(NUM_LANES)-1:0] cmd_lane,
    input  logic [$clog2(DEPTH)-1:0]     cmd_addr,
    input  logic                         cmd_weight,
    input  logic                         cmd_mask,
    input  logic [$clog2(DEPTH+1)-1:0]   cmd_len,
    input  logic                         act_valid,
    input  logic [NUM_LANES-1:0]         act,
    output logic                         busy,
    output logic                         done,
    output logic signed [ACC_W-1:0]      total,
    output logic                         sign_bit
);

    import sign_vote_pkg::*;

    logic  run_start;
    vote_t lane_vote  [NUM_LANES];
    // all lanes in lockstep, lane 0 flags drive the counter
    logic  lane_valid [NUM_LANES];
    logic  lane_last  [NUM_LANES];

    lane_bus_if #(.NUM_LANES(NUM_LANES), .DEPTH(DEPTH)) bus ();

    lane_loader #(.NUM_LANES(NUM_LANES), .DEPTH(DEPTH)) u_loader (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_lane   (cmd_lane),
        .cmd_addr   (cmd_addr),
        .cmd_weight (cmd_weight),
        .cmd_mask   (cmd_mask),
        .cmd_len    (cmd_len),
        .act_valid  (act_valid),
        .act        (act),
        .busy       (busy),
        .run_start  (run_start),
        .bus        (bus.src)
    );

    // one lane per activation bit
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        vote_lane #(.LANE_ID(i), .DEPTH(DEPTH)) u_lane (
            .clk        (clk),
            .rst        (rst),
            .bus        (bus.dst),
            .vote       (lane_vote[i]),
            .vote_valid (lane_valid[i]),
            .vote_last  (lane_last[i])
        );
    end

    vote_counter #(.NUM_LANES(NUM_LANES), .ACC_W(ACC_W)) u_counter (
        .clk        (clk),
        .rst        (rst),
        .run_start  (run_start),
        .votes      (lane_vote),
        .vote_valid (lane_valid[0]),
        .vote_last  (lane_last[0]),
        .total      (total),
        .sign_bit   (sign_bit),
        .done       (done)
    );

endmodule

//--- rtl/vote_counter.sv
`timescale 1ns/1ns

module vote_counter #(
    parameter int NUM_LANES = 16,
    parameter int ACC_W     = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run_start,
    input  sign_vote_pkg::vote_t    votes [NUM_LANES],
    input  logic                    vote_valid,
    input  logic                    vote_last,
    output logic signed [ACC_W-1:0] total,
    output logic                    sign_bit,
    output logic                    done
);

    // holds -NUM_LANES .. +NUM_LANES
    localparam int SUM_W = $clog2(NUM_LANES + 1) + 1;

    logic signed [SUM_W-1:0] step_sum;
    logic signed [SUM_W-1:0] sum_q;
    logic                    sum_valid;
    logic                    sum_last;
    logic                    added_last;
    logic signed [ACC_W-1:0] acc;

    // adder tree over all lanes, signed context sign-extends each vote
    always_comb begin
        step_sum = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            step_sum = step_sum + votes[i];
        end
    end

    // stage 1, registered step sum
    always_ff @(posedge clk) begin
        if (vote_valid) begin
            sum_q <= step_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
            sum_last  <= 1'b0;
        end else begin
            sum_valid <= vote_valid;
            sum_last  <= vote_valid && vote_last;
        end
    end

    // stage 2, accumulate; run_start wins over a stale sum
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (run_start) begin
            acc <= '0;
        end else if (sum_valid) begin
            acc <= acc + sum_q;
        end
    end

    // done one cycle after the final add
    always_ff @(posedge clk) begin
        if (rst) begin
            added_last <= 1'b0;
            done       <= 1'b0;
        end else begin
            added_last <= sum_valid && sum_last;
            done       <= added_last;
        end
    end

    assign total    = acc;
    // sign read straight off the accumulator
    assign sign_bit = acc[ACC_W-1];

endmodule

//--- rtl/vote_lane.sv
`timescale 1ns/1ns

module vote_lane #(
    parameter int LANE_ID = 0,
    parameter int DEPTH   = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    lane_bus_if.dst              bus,
    output sign_vote_pkg::vote_t vote,
    output logic                 vote_valid,
    output logic                 vote_last
);

    import sign_vote_pkg::*;

    // weight and mask per step
    logic weight_mem [DEPTH];
    logic mask_mem   [DEPTH];

    logic lane_sel;
    logic rd_weight;
    logic rd_mask;
    logic act_bit;

    // writes for this lane only
    assign lane_sel = bus.wr_en && (int'(bus.wr_lane) == LANE_ID);

    always_ff @(posedge clk) begin
        if (lane_sel) begin
            weight_mem[bus.wr_addr] <= bus.wr_weight;
            mask_mem[bus.wr_addr]   <= bus.wr_mask;
        end
    end

    // async table read at the broadcast step
    assign rd_weight = weight_mem[bus.step_addr];
    assign rd_mask   = mask_mem[bus.step_addr];
    // own bit of the shared activation vector
    assign act_bit   = bus.step_act[LANE_ID];

    // vote register, meaningful with vote_valid
    always_ff @(posedge clk) begin
        if (bus.step_valid) begin
            if (!rd_mask) begin
                vote <= VOTE_ZERO;
            end else if (act_bit == rd_weight) begin
                vote <= VOTE_POS;
            end else begin
                vote <= VOTE_NEG;
            end
        end
    end

    // flags run in lockstep with every other lane
    always_ff @(posedge clk) begin
        if (rst) begin
            vote_valid <= 1'b0;
            vote_last  <= 1'b0;
        end else begin
            vote_valid <= bus.step_valid;
            vote_last  <= bus.step_valid && bus.step_last;
        end
    end

endmodule

//--- sign_vote.f
rtl/sign_vote_pkg.sv
rtl/lane_bus_if.sv
rtl/lane_loader.sv
rtl/vote_lane.sv
rtl/vote_counter.sv
rtl/sign_vote_top.sv
sim/sign_vote_assert.sv
sim/sign_vote_tb.sv

//--- sim/sign_vote_assert.sv
`timescale 1ns/1ns

module sign_vote_assert (
    input logic clk,
    input logic rst,
    input logic cmd_valid,
    input logic busy,
    input logic done,
    input logic run_start,
    input logic wr_en
);

    // loader idle and no done pulse straight out of reset
    a_reset_idle: assert property (
        @(posedge clk) rst |=> (!busy && !done)
    ) else $error("busy or done high after reset");

    // single cycle done pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    ) else $error("done held for more than one cycle");

    // busy drops exactly when done pulses
    a_busy_falls_with_done: assert property (
        @(posedge clk) disable iff (rst) $fell(busy) |-> done
    ) else $error("busy fell without done");

    a_done_not_busy: assert property (
        @(posedge clk) disable iff (rst) done |-> !busy
    ) else $error("done pulsed while still busy");

    // commands while busy leave no trace on the lane bus
    a_no_cmd_while_busy: assert property (
        @(posedge clk) disable iff (rst) (busy && cmd_valid) |=> (!run_start && !wr_en)
    ) else $error("command accepted while busy");

endmodule

bind sign_vote_top sign_vote_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .busy      (busy),
    .done      (done),
    .run_start (run_start),
    .wr_en     (bus.wr_en)
);

//--- sim/sign_vote_tb.sv
`timescale 1ns/1ns

module sign_vote_tb;

    import sign_vote_pkg::*;

    localparam int NUM_LANES = 16;
    localparam int DEPTH     = 32;
    localparam int ACC_W     = 16;
    localparam int LANE_W    = $clog2(NUM_LANES);
    localparam int ADDR_W    = $clog2(DEPTH);
    localparam int LEN_W     = $clog2(DEPTH + 1);

    // act drive edge to done: step, vote, sum, acc, done
    localparam int DONE_LATENCY = 5;
    localparam int GAP_LEN      = 20;
    localparam int PRE_PULSES   = 4;
    localparam int BUSY_LEN     = 6;
    // loads + run steps + 8 per run, gaps counted as extra steps
    localparam int T1_CYCLES   = NUM_LANES + 1 + 8;
    localparam int T2_CYCLES   = NUM_LANES + 2 + 2 * 8;
    localparam int T3_CYCLES   = NUM_LANES * DEPTH + DEPTH + 8;
    localparam int T4_CYCLES   = 2 * PRE_PULSES + 2 * GAP_LEN + 8;
    localparam int T5_CYCLES   = 2 * BUSY_LEN + 2 * 8;
    localparam int CYCLE_LIMIT = T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                 + T5_CYCLES + 200;

    logic                    clk;
    logic                    rst;
    logic                    cmd_valid;
    op_t                     cmd_op;
    logic [LANE_W-1:0]       cmd_lane;
    logic [ADDR_W-1:0]       cmd_addr;
    logic                    cmd_weight;
    logic                    cmd_mask;
    logic [LEN_W-1:0]        cmd_len;
    logic                    act_valid;
    logic [NUM_LANES-1:0]    act;
    logic                    busy;
    logic                    done;
    logic signed [ACC_W-1:0] total;
    logic                    sign_bit;

    // mirror of every lane table
    logic        model_weight [NUM_LANES][DEPTH];
    logic        model_mask   [NUM_LANES][DEPTH];
    int          exp_total;
    int          step_idx;
    int          cycle_count = 0;
    logic [31:0] rng_state;

    sign_vote_top #(.NUM_LANES(NUM_LANES), .DEPTH(DEPTH), .ACC_W(ACC_W)) dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_lane   (cmd_lane),
        .cmd_addr   (cmd_addr),
        .cmd_weight (cmd_weight),
        .cmd_mask   (cmd_mask),
        .cmd_len    (cmd_len),
        .act_valid  (act_valid),
        .act        (act),
        .busy       (busy),
        .done       (done),
        .total      (total),
        .sign_bit   (sign_bit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure("timeout, the tests did not finish within the cycle limit");
        end
    end

    task automatic report_failure(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_random();
        return r[0];
    endfunction

    // +1 on agreement, -1 on disagreement, masked lanes abstain
    function automatic int expected_step_sum(input logic [NUM_LANES-1:0] vec, input int addr);
        int sum;
        sum = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (model_mask[l][addr]) begin
                sum = (vec[l] == model_weight[l][addr]) ? sum + 1 : sum - 1;
            end
        end
        return sum;
    endfunction

    // weights of one table entry across all lanes
    function automatic logic [NUM_LANES-1:0] weight_vector(input int addr);
        logic [NUM_LANES-1:0] vec;
        for (int l = 0; l < NUM_LANES; l++) begin
            vec[l] = model_weight[l][addr];
        end
        return vec;
    endfunction

    task automatic check_total(input string name, input logic signed [ACC_W-1:0] expected,
                               input logic signed [ACC_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, expected, actual);
            report_failure("accumulator value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, expected, actual);
            report_failure("single bit output mismatch");
        end
    endtask

    task automatic check_state(input string name, input loader_state_t expected,
                               input loader_state_t actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, expected, actual);
            report_failure("loader state mismatch");
        end
    endtask

    task automatic load_entry(input int lane, input int addr, input logic w, input logic m);
        @(posedge clk);
        cmd_valid  <= 1'b1;
        cmd_op     <= OP_LOAD;
        cmd_lane   <= LANE_W'(lane);
        cmd_addr   <= ADDR_W'(addr);
        cmd_weight <= w;
        cmd_mask   <= m;
        model_weight[lane][addr] = w;
        model_mask[lane][addr]   = m;
    endtask

    task automatic end_cmd();
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic start_run(input int len);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= OP_RUN;
        cmd_len   <= LEN_W'(len);
        @(posedge clk);
        cmd_valid <= 1'b0;
        exp_total = 0;
        step_idx  = 0;
        // busy one cycle after acceptance
        @(negedge clk);
        check_bit("busy", 1'b1, busy);
    endtask

    // one accepted step, folded into the model
    task automatic send_act(input logic [NUM_LANES-1:0] vec);
        @(posedge clk);
        act_valid <= 1'b1;
        act       <= vec;
        exp_total = exp_total + expected_step_sum(vec, step_idx);
        step_idx++;
    endtask

    task automatic idle_act();
        @(posedge clk);
        act_valid <= 1'b0;
        act       <= NUM_LANES'(next_random());
    endtask

    // inputs idle while the last step drains
    task automatic finish_run();
        int latency;
        latency = 0;
        do begin
            @(posedge clk);
            act_valid <= 1'b0;
            cmd_valid <= 1'b0;
            latency++;
            @(negedge clk);
            if (latency > 4 * DONE_LATENCY) begin
                report_failure("done never pulsed after the last activation");
            end
        end while (!done);
        if (latency != DONE_LATENCY) begin
            report_failure("done did not pulse five cycles after the last activation");
        end
        check_bit("busy", 1'b0, busy);
        check_total("total", ACC_W'(exp_total), total);
        check_bit("sign_bit", exp_total < 0, sign_bit);
        check_state("state", ST_IDLE, dut.u_loader.state);
    endtask

    task automatic test_after_reset();
        @(negedge clk);
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        check_bit("sign_bit", 1'b0, sign_bit);
        check_total("total", '0, total);
        check_state("state", ST_IDLE, dut.u_loader.state);
        // every lane abstains on entry 0
        for (int l = 0; l < NUM_LANES; l++) begin
            load_entry(l, 0, rand_bit(), 1'b0);
        end
        end_cmd();
        start_run(1);
        send_act(NUM_LANES'(next_random()));
        finish_run();
        check_total("total", '0, total);
    endtask

    task automatic test_agree_disagree();
        logic [NUM_LANES-1:0] wvec;
        for (int l = 0; l < NUM_LANES; l++) begin
            load_entry(l, 0, rand_bit(), 1'b1);
        end
        end_cmd();
        for (int l = 0; l < NUM_LANES; l++) begin
            wvec[l] = model_weight[l][0];
        end
        start_run(1);
        send_act(wvec);
        finish_run();
        check_total("total", ACC_W'(NUM_LANES), total);
        // second run must start from a cleared accumulator
        start_run(1);
        send_act(~wvec);
        finish_run();
        check_total("total", ACC_W'(-NUM_LANES), total);
        check_bit("sign_bit", 1'b1, sign_bit);
    endtask

    task automatic test_random_full();
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int a = 0; a < DEPTH; a++) begin
                load_entry(l, a, rand_bit(), rand_bit());
            end
        end
        end_cmd();
        // back to back, several steps in flight
        start_run(DEPTH);
        for (int k = 0; k < DEPTH; k++) begin
            send_act(NUM_LANES'(next_random()));
        end
        finish_run();
    endtask

    task automatic test_gapped_acts();
        // strobes while idle never reach the lanes
        for (int i = 0; i < PRE_PULSES; i++) begin
            @(posedge clk);
            act_valid <= 1'b1;
            act       <= NUM_LANES'(next_random());
            idle_act();
            @(negedge clk);
            check_total("total", ACC_W'(exp_total), total);
            check_bit("done", 1'b0, done);
        end
        // a stray step would have reached the accumulator by now
        repeat (DONE_LATENCY) begin
            @(negedge clk);
            check_total("total", ACC_W'(exp_total), total);
            check_bit("done", 1'b0, done);
            check_bit("busy", 1'b0, busy);
        end
        start_run(GAP_LEN);
        for (int k = 0; k < GAP_LEN; k++) begin
            if (rand_bit()) begin
                idle_act();
            end
            send_act(NUM_LANES'(next_random()));
        end
        finish_run();
    endtask

    task automatic test_busy_protocol();
        logic signed [ACC_W-1:0] held;
        // loads that would flip entries, dropped while busy
        start_run(BUSY_LEN);
        for (int k = 0; k < BUSY_LEN; k++) begin
            send_act(NUM_LANES'(next_random()));
            cmd_valid  <= 1'b1;
            cmd_op     <= OP_LOAD;
            cmd_lane   <= LANE_W'(k % NUM_LANES);
            cmd_addr   <= ADDR_W'(k);
            cmd_weight <= ~model_weight[k % NUM_LANES][k];
            cmd_mask   <= ~model_mask[k % NUM_LANES][k];
        end
        finish_run();
        // same entries again, model untouched
        // act equal to the stored weights, so any flipped entry lowers the sum
        start_run(BUSY_LEN);
        for (int k = 0; k < BUSY_LEN; k++) begin
            send_act(weight_vector(k));
        end
        finish_run();
        held = ACC_W'(exp_total);
        repeat (4) begin
            @(negedge clk);
            check_total("total", held, total);
            check_bit("sign_bit", exp_total < 0, sign_bit);
            check_bit("done", 1'b0, done);
            check_bit("busy", 1'b0, busy);
        end
    endtask

    initial begin
        rng_state = 32'd9;
        rst        <= 1'b1;
        cmd_valid  <= 1'b0;
        cmd_op     <= OP_LOAD;
        cmd_lane   <= '0;
        cmd_addr   <= '0;
        cmd_weight <= 1'b0;
        cmd_mask   <= 1'b0;
        cmd_len    <= '0;
        act_valid  <= 1'b0;
        act        <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_after_reset();
        test_agree_disagree();
        test_random_full();
        test_gapped_acts();
        test_busy_protocol();
        $display("=== PASS ===");
        $finish;
    end

endmodule
